// ==== build.f ====
logic/mem_sys_pkg.sv
logic/cache_pkg.sv
logic/dm_cache.sv
logic/banked_mem.sv
logic/cache_ctrl_fsm.sv
logic/mem_system.sv
verif/mem_system_assert.sv
verif/mem_system_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cached memory system testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module mem_system_tb \
   -f build.f -o mem_system_sim

./obj_dir/mem_system_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log || ! grep -q "TEST PASSED" sim.log; then
   echo "Simulation reported a failure"
   exit 1
fi

// ==== verif/mem_system_tb.sv ====
// Testbench for the cached memory system
// Directed and random processor traffic checked against a shadow
// word array and a per-line tag and valid model
`timescale 1ns/1ps

module mem_system_tb;

   localparam int TIMEOUT_CYCLES = 200;

   logic               clk;
   logic               rst_n;
   mem_sys_pkg::addr_t addr;
   mem_sys_pkg::data_t data_in;
   logic               rd;
   logic               wr;
   mem_sys_pkg::data_t data_out;
   logic               done;
   logic               stall;
   logic               cache_hit;
   logic               err;

   mem_sys_pkg::data_t shadow      [mem_sys_pkg::MEM_WORDS];
   cache_pkg::tag_t    model_tag   [cache_pkg::NUM_LINES];
   logic               model_valid [cache_pkg::NUM_LINES];
   logic [31:0]        rng;

   mem_system mem_system_i (.*);

   initial clk = 1'b0;
   always #5 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic report_mismatch(input string name, input logic [15:0] exp,
                                  input logic [15:0] act);
      stop_with_failure($sformatf("[ERROR] %0t: %s expected %h, got %h",
                                  $time, name, exp, act));
   endtask

   // Stall must cover every cycle from the request edge up to done
   task automatic wait_for_done();
      int cycles;
      cycles = 0;
      @(negedge clk);
      assert (!stall) else report_mismatch("stall", 16'd0, 16'(stall));
      @(negedge clk);
      while (!done && cycles < TIMEOUT_CYCLES) begin
         assert (stall) else report_mismatch("stall", 16'd1, 16'(stall));
         @(negedge clk);
         cycles++;
      end
      if (!done) begin
         stop_with_failure("Timed out waiting for done");
      end
   endtask

   // One legal read or write, checked and then folded into the model
   task automatic access(input logic is_wr, input mem_sys_pkg::addr_t a,
                         input mem_sys_pkg::data_t d);
      cache_pkg::tag_t   tag;
      cache_pkg::index_t idx;
      logic              exp_hit;
      tag     = a[15:11];
      idx     = a[10:3];
      exp_hit = model_valid[idx] && (model_tag[idx] == tag);
      @(posedge clk);
      #1;
      addr    = a;
      data_in = d;
      rd      = !is_wr;
      wr      = is_wr;
      wait_for_done();
      assert (cache_hit == exp_hit)
         else report_mismatch("cache_hit", 16'(exp_hit), 16'(cache_hit));
      if (!is_wr) begin
         assert (data_out == shadow[a[15:1]])
            else report_mismatch("data_out", shadow[a[15:1]], data_out);
      end else begin
         shadow[a[15:1]] = d;
      end
      model_valid[idx] = 1'b1;
      model_tag[idx]   = tag;
      @(posedge clk);
      #1;
      rd = 1'b0;
      wr = 1'b0;
   endtask

   // Request held for a single edge so err pulses once without done
   task automatic illegal_request(input logic rd_v, input logic wr_v,
                                  input mem_sys_pkg::addr_t a);
      int cycles;
      @(posedge clk);
      #1;
      addr    = a;
      data_in = 16'hdead;
      rd      = rd_v;
      wr      = wr_v;
      @(posedge clk);
      #1;
      rd     = 1'b0;
      wr     = 1'b0;
      cycles = 0;
      @(negedge clk);
      while (!err && cycles < TIMEOUT_CYCLES) begin
         assert (!done) else report_mismatch("done", 16'd0, 16'(done));
         @(negedge clk);
         cycles++;
      end
      if (!err) begin
         stop_with_failure("Timed out waiting for err");
      end
      assert (!done) else report_mismatch("done", 16'd0, 16'(done));
      @(negedge clk);
      assert (!err) else report_mismatch("err", 16'd0, 16'(err));
      assert (!done) else report_mismatch("done", 16'd0, 16'(done));
   endtask

   initial begin
      mem_sys_pkg::addr_t line_a;
      mem_sys_pkg::addr_t line_b;
      mem_sys_pkg::addr_t ra;
      rst_n   = 1'b0;
      addr    = '0;
      data_in = '0;
      rd      = 1'b0;
      wr      = 1'b0;
      rng     = 32'h6a9e;
      foreach (shadow[i]) shadow[i] = '0;
      foreach (model_valid[i]) begin
         model_valid[i] = 1'b0;
         model_tag[i]   = '0;
      end
      // Same index 5, tags 1 and 2, word 2
      line_a = 16'h082c;
      line_b = 16'h102c;

      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(negedge clk);
      assert (!done) else report_mismatch("done", 16'd0, 16'(done));
      assert (!stall) else report_mismatch("stall", 16'd0, 16'(stall));
      assert (!err) else report_mismatch("err", 16'd0, 16'(err));
      assert (!cache_hit) else report_mismatch("cache_hit", 16'd0, 16'(cache_hit));

      access(1'b0, 16'h0040, '0);
      access(1'b1, line_a, 16'hbeef);
      access(1'b0, line_a, '0);
      // Conflict forces write-back of the dirty line
      access(1'b1, line_b, 16'h1357);
      access(1'b0, line_a, '0);
      for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
         access(1'b0, {line_a[15:3], 2'(w), 1'b0}, '0);
      end

      // Small tag and index set keeps conflicts frequent
      for (int n = 0; n < 200; n++) begin
         rng = xorshift(rng);
         ra  = {3'b000, rng[1:0], 6'b000000, rng[3:2], rng[5:4], 1'b0};
         access(rng[8], ra, rng[31:16]);
      end

      illegal_request(1'b1, 1'b1, line_a);
      illegal_request(1'b1, 1'b0, line_a | 16'h0001);
      access(1'b0, line_a, '0);

      $display("TEST PASSED");
      $finish;
   end

endmodule

// ==== verif/mem_system_assert.sv ====
// Protocol checks for the cached memory system
// Done, stall, err and hit relations plus the one-cycle hit latency
`timescale 1ns/1ps

module mem_system_assert (
   input logic               clk,
   input logic               rst_n,
   input mem_sys_pkg::addr_t addr,
   input logic               rd,
   input logic               wr,
   input logic               done,
   input logic               stall,
   input logic               cache_hit,
   input logic               err
);

   logic legal_req_idle;

   // Controller is idle exactly when neither stall nor done is up
   assign legal_req_idle = !stall && !done && (rd ^ wr) && !addr[0];

   hit_needs_done: assert property (@(posedge clk) disable iff (!rst_n)
      cache_hit |-> done)
      else $error("cache_hit high without done");

   done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      done |=> !done)
      else $error("done high for two cycles");

   stall_done_apart: assert property (@(posedge clk) disable iff (!rst_n)
      !(stall && done))
      else $error("stall and done high together");

   err_done_apart: assert property (@(posedge clk) disable iff (!rst_n)
      !(err && done))
      else $error("err and done high together");

   // A hit answers in the cycle right after its request edge
   hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
      cache_hit |-> $past(legal_req_idle))
      else $error("hit not one cycle after the request");

   // After a request the lookup either hits or starts the stall
   req_starts_lookup: assert property (@(posedge clk) disable iff (!rst_n)
      legal_req_idle |=> (cache_hit || stall))
      else $error("request followed by neither a hit nor a stall");

endmodule

bind mem_system mem_system_assert assert_i (
   .clk        (clk),
   .rst_n      (rst_n),
   .addr       (addr),
   .rd         (rd),
   .wr         (wr),
   .done       (done),
   .stall      (stall),
   .cache_hit  (cache_hit),
   .err        (err)
);

// ==== logic/mem_system.sv ====
// Cached memory system top level
// Controller FSM, direct-mapped cache and four-bank main memory
`timescale 1ns/1ps

module mem_system (
   input  logic               clk,
   input  logic               rst_n,
   input  mem_sys_pkg::addr_t addr,
   input  mem_sys_pkg::data_t data_in,
   input  logic               rd,
   input  logic               wr,
   output mem_sys_pkg::data_t data_out,
   output logic               done,
   output logic               stall,
   output logic               cache_hit,
   output logic               err
);

   cache_pkg::cache_req_t cache_req;
   cache_pkg::cache_rsp_t cache_rsp;
   mem_sys_pkg::mem_req_t mem_req;
   mem_sys_pkg::data_t    mem_data;
   logic                  mem_stall;

   // Reads always return through the cache
   assign data_out = cache_rsp.data;

   cache_ctrl_fsm ctrl_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .cache_req (cache_req),
      .cache_rsp (cache_rsp),
      .mem_req   (mem_req),
      .mem_data  (mem_data),
      .mem_stall (mem_stall),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   dm_cache cache_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .cache_req (cache_req),
      .cache_rsp (cache_rsp)
   );

   banked_mem mem_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .mem_req (mem_req),
      .data    (mem_data),
      .busy    (),
      .stall   (mem_stall)
   );

endmodule

// ==== logic/cache_ctrl_fsm.sv ====
// Cache controller FSM
// Checks each processor request, looks it up, writes back a dirty
// victim, refills the line from banked memory and finishes the access
`timescale 1ns/1ps

module cache_ctrl_fsm (
   input  logic                  clk,
   input  logic                  rst_n,
   input  mem_sys_pkg::addr_t    addr,
   input  mem_sys_pkg::data_t    data_in,
   input  logic                  rd,
   input  logic                  wr,
   output cache_pkg::cache_req_t cache_req,
   input  cache_pkg::cache_rsp_t cache_rsp,
   output mem_sys_pkg::mem_req_t mem_req,
   input  mem_sys_pkg::data_t    mem_data,
   input  logic                  mem_stall,
   output logic                  done,
   output logic                  stall,
   output logic                  cache_hit,
   output logic                  err
);

   localparam int WCNT_W = $clog2(cache_pkg::WORDS_PER_LINE);
   localparam logic [WCNT_W-1:0] LAST_WORD = WCNT_W'(cache_pkg::WORDS_PER_LINE - 1);
   localparam int LAT = mem_sys_pkg::MEM_RD_LATENCY;

   cache_pkg::ctrl_state_t state;
   cache_pkg::ctrl_state_t state_nxt;

   cache_pkg::tag_t   req_tag;
   cache_pkg::index_t req_index;
   logic [WCNT_W-1:0] word_cnt;
   logic [WCNT_W-1:0] ret_cnt;
   logic [LAT-1:0]    rd_pipe;
   logic              ret_valid;
   logic              req;
   logic              illegal;
   logic              issue_ok;

   assign req_tag   = addr[15:11];
   assign req_index = addr[10:3];
   assign req       = rd || wr;
   // Both strobes at once or an odd address
   assign illegal   = (rd && wr) || addr[0];
   assign issue_ok  = !mem_stall;
   // Fill word arriving from memory this cycle
   assign ret_valid = rd_pipe[LAT-1];

   assign cache_hit = (state == cache_pkg::LOOKUP) && cache_rsp.hit;
   assign done      = cache_hit || (state == cache_pkg::FINISH);
   assign stall     = (state != cache_pkg::IDLE) && !done;

   always_comb begin
      state_nxt = state;
      case (state)
         cache_pkg::IDLE:
            if (req && !illegal) state_nxt = cache_pkg::LOOKUP;
         cache_pkg::LOOKUP:
            if (cache_rsp.hit) state_nxt = cache_pkg::IDLE;
            else if (cache_rsp.valid && cache_rsp.dirty) state_nxt = cache_pkg::WB_ISSUE;
            else state_nxt = cache_pkg::FILL_ISSUE;
         cache_pkg::WB_ISSUE:
            if (issue_ok) state_nxt = cache_pkg::WB_WAIT;
         // Counter wraps to zero once the whole line is written back
         cache_pkg::WB_WAIT:
            if (word_cnt == '0) state_nxt = cache_pkg::FILL_ISSUE;
            else state_nxt = cache_pkg::WB_ISSUE;
         cache_pkg::FILL_ISSUE:
            if (issue_ok && (word_cnt == LAST_WORD)) state_nxt = cache_pkg::FILL_WAIT;
         cache_pkg::FILL_WAIT:
            if (ret_valid && (ret_cnt == LAST_WORD)) state_nxt = cache_pkg::ACCESS;
         cache_pkg::ACCESS:
            state_nxt = cache_pkg::FINISH;
         default:
            state_nxt = cache_pkg::IDLE;
      endcase
   end

   always_comb begin
      cache_req        = '0;
      cache_req.tag    = req_tag;
      cache_req.index  = req_index;
      cache_req.offset = addr[2:0];
      cache_req.data   = data_in;
      mem_req          = '0;
      case (state)
         cache_pkg::LOOKUP, cache_pkg::ACCESS: begin
            cache_req.enable = 1'b1;
            cache_req.comp   = 1'b1;
            cache_req.write  = wr;
         end
         // Read back the word for data_out
         cache_pkg::FINISH: begin
            cache_req.enable = 1'b1;
            cache_req.comp   = 1'b1;
         end
         // Victim word goes to the address of the stored tag
         cache_pkg::WB_ISSUE: begin
            cache_req.enable = 1'b1;
            cache_req.offset = {word_cnt, 1'b0};
            mem_req.wr       = 1'b1;
            mem_req.addr     = {cache_rsp.tag, req_index, word_cnt, 1'b0};
            mem_req.data     = cache_rsp.data;
         end
         cache_pkg::FILL_ISSUE, cache_pkg::FILL_WAIT: begin
            if (ret_valid) begin
               cache_req.enable   = 1'b1;
               cache_req.write    = 1'b1;
               cache_req.valid_in = 1'b1;
               cache_req.offset   = {ret_cnt, 1'b0};
               cache_req.data     = mem_data;
            end
            if (state == cache_pkg::FILL_ISSUE) begin
               mem_req.rd   = 1'b1;
               mem_req.addr = {req_tag, req_index, word_cnt, 1'b0};
            end
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= cache_pkg::IDLE;
         word_cnt <= '0;
         ret_cnt  <= '0;
         rd_pipe  <= '0;
         err      <= 1'b0;
      end else begin
         state   <= state_nxt;
         err     <= (state == cache_pkg::IDLE) && req && illegal;
         // Tracks fill reads in flight
         rd_pipe <= {rd_pipe[LAT-2:0], (state == cache_pkg::FILL_ISSUE) && issue_ok};
         if (state == cache_pkg::IDLE) begin
            word_cnt <= '0;
            ret_cnt  <= '0;
         end else begin
            if ((state == cache_pkg::WB_ISSUE || state == cache_pkg::FILL_ISSUE) && issue_ok) begin
               word_cnt <= word_cnt + 1'b1;
            end
            if (ret_valid) begin
               ret_cnt <= ret_cnt + 1'b1;
            end
         end
      end
   end

endmodule

// ==== logic/banked_mem.sv ====
// Four-bank word-interleaved main memory
// Each bank is busy for a fixed number of cycles after an access and
// reads return through a fixed-latency pipeline
`timescale 1ns/1ps

module banked_mem (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  mem_sys_pkg::mem_req_t                mem_req,
   output mem_sys_pkg::data_t                   data,
   output logic [mem_sys_pkg::NUM_BANKS-1:0]    busy,
   output logic                                 stall
);

   localparam int WORD_W = $clog2(mem_sys_pkg::MEM_WORDS);
   localparam int CNT_W  = $clog2(mem_sys_pkg::BANK_BUSY_CYCLES + 1);

   mem_sys_pkg::data_t mem_arr [mem_sys_pkg::MEM_WORDS];
   mem_sys_pkg::data_t rd_pipe [mem_sys_pkg::MEM_RD_LATENCY];

   logic [CNT_W-1:0]   busy_cnt [mem_sys_pkg::NUM_BANKS];
   logic [WORD_W-1:0]  word_addr;
   mem_sys_pkg::bank_t bank;
   logic               access;
   logic               accept;

   assign word_addr = mem_req.addr[15:1];
   // Consecutive words land in consecutive banks
   assign bank      = mem_req.addr[2:1];
   assign access    = mem_req.rd || mem_req.wr;
   assign stall     = access && busy[bank];
   assign accept    = access && !busy[bank];
   assign data      = rd_pipe[mem_sys_pkg::MEM_RD_LATENCY-1];

   always_comb begin
      for (int b = 0; b < mem_sys_pkg::NUM_BANKS; b++) begin
         busy[b] = (busy_cnt[b] != '0);
      end
   end

   // Per-bank busy counters
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int b = 0; b < mem_sys_pkg::NUM_BANKS; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < mem_sys_pkg::NUM_BANKS; b++) begin
            if (accept && (bank == mem_sys_pkg::bank_t'(b))) begin
               busy_cnt[b] <= CNT_W'(mem_sys_pkg::BANK_BUSY_CYCLES);
            end else if (busy[b]) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   // Memory contents start cleared
   initial begin
      for (int i = 0; i < mem_sys_pkg::MEM_WORDS; i++) begin
         mem_arr[i] = '0;
      end
   end

   // Word array and read pipeline
   always @(posedge clk) begin
      if (accept && mem_req.wr) begin
         mem_arr[word_addr] <= mem_req.data;
      end
      if (accept && mem_req.rd) begin
         rd_pipe[0] <= mem_arr[word_addr];
      end
      for (int s = 1; s < mem_sys_pkg::MEM_RD_LATENCY; s++) begin
         rd_pipe[s] <= rd_pipe[s-1];
      end
   end

endmodule

// ==== logic/dm_cache.sv ====
// Direct-mapped cache arrays
// Tag, valid, dirty and data storage with combinational lookup and
// edge-triggered writes in compare or plain mode
`timescale 1ns/1ps

module dm_cache (
   input  logic                  clk,
   input  logic                  rst_n,
   input  cache_pkg::cache_req_t cache_req,
   output cache_pkg::cache_rsp_t cache_rsp
);

   localparam int WORD_IDX_W = $clog2(cache_pkg::NUM_LINES * cache_pkg::WORDS_PER_LINE);

   cache_pkg::tag_t    tag_arr  [cache_pkg::NUM_LINES];
   mem_sys_pkg::data_t data_arr [cache_pkg::NUM_LINES * cache_pkg::WORDS_PER_LINE];

   logic [cache_pkg::NUM_LINES-1:0] valid_arr;
   logic [cache_pkg::NUM_LINES-1:0] dirty_arr;

   logic [WORD_IDX_W-1:0] word_idx;
   logic                  tag_match;
   logic                  line_wr;

   // Word select within the line ignores the byte bit
   assign word_idx  = {cache_req.index, cache_req.offset[2:1]};
   assign tag_match = (tag_arr[cache_req.index] == cache_req.tag);

   assign cache_rsp.valid = valid_arr[cache_req.index];
   assign cache_rsp.dirty = dirty_arr[cache_req.index];
   assign cache_rsp.tag   = tag_arr[cache_req.index];
   assign cache_rsp.data  = data_arr[word_idx];
   assign cache_rsp.hit   = cache_req.enable && valid_arr[cache_req.index] && tag_match;

   // Compare writes only land on a hit while plain writes always land
   assign line_wr = cache_req.enable && cache_req.write &&
                    (!cache_req.comp || cache_rsp.hit);

   // Line state
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_arr <= '0;
         dirty_arr <= '0;
      end else if (line_wr) begin
         if (cache_req.comp) begin
            dirty_arr[cache_req.index] <= 1'b1;
         end else begin
            valid_arr[cache_req.index] <= cache_req.valid_in;
            dirty_arr[cache_req.index] <= 1'b0;
         end
      end
   end

   // Tag and word storage
   always_ff @(posedge clk) begin
      if (line_wr) begin
         data_arr[word_idx] <= cache_req.data;
         if (!cache_req.comp) begin
            tag_arr[cache_req.index] <= cache_req.tag;
         end
      end
   end

endmodule

// ==== logic/cache_pkg.sv ====
// Cache side definitions
// Geometry of the direct-mapped cache, the cache request and response
// structs and the controller state encoding
package cache_pkg;

   typedef logic [4:0] tag_t;
   typedef logic [7:0] index_t;
   typedef logic [2:0] offset_t;

   localparam int NUM_LINES      = 256;
   localparam int WORDS_PER_LINE = 4;

   // Request from the controller to the cache arrays
   typedef struct packed {
      logic               enable;
      logic               comp;
      logic               write;
      logic               valid_in;
      tag_t               tag;
      index_t             index;
      offset_t            offset;
      mem_sys_pkg::data_t data;
   } cache_req_t;

   // Response with hit already qualified by valid
   typedef struct packed {
      logic               hit;
      logic               dirty;
      logic               valid;
      tag_t               tag;
      mem_sys_pkg::data_t data;
   } cache_rsp_t;

   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      WB_ISSUE,
      WB_WAIT,
      FILL_ISSUE,
      FILL_WAIT,
      ACCESS,
      FINISH
   } ctrl_state_t;

endpackage

// ==== logic/mem_sys_pkg.sv ====
// Processor and main-memory side definitions
// Byte addresses, data words, bank numbers, the controller's memory
// request and the timing of the banked main memory
package mem_sys_pkg;

   // Byte address from the processor
   typedef logic [15:0] addr_t;

   // One data word
   typedef logic [15:0] data_t;

   // Bank number, taken from address bits 2 to 1
   typedef logic [1:0] bank_t;

   // Controller request to main memory
   typedef struct packed {
      logic  rd;
      logic  wr;
      addr_t addr;
      data_t data;
   } mem_req_t;

   // Memory size in words
   localparam int MEM_WORDS = 32768;

   // Word-interleaved banks
   localparam int NUM_BANKS = 4;

   // Cycles a bank stays busy after it accepts an access
   localparam int BANK_BUSY_CYCLES = 4;

   // Read data shows up this many cycles after acceptance
   localparam int MEM_RD_LATENCY = 2;

endpackage
